/* hw/apb_watch_pkg.sv */
// APB watch shared widths, register map and bus observation types
package apb_watch_pkg;

	////////////////////////////////////////////////////////////
	// Bus and register widths
	////////////////////////////////////////////////////////////

	// Observed APB segment
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// Configuration port
	localparam int CFG_AW = 5;
	localparam int CFG_DW = 32;

	// Stall counter, stall limit and longest stall
	localparam int STALL_W = 8;

	// One status bit per violation kind
	localparam int VIOL_N = 6;

	////////////////////////////////////////////////////////////
	// Register map
	////////////////////////////////////////////////////////////

	localparam logic [CFG_AW-1:0] REG_CTRL      = 'h00;
	localparam logic [CFG_AW-1:0] REG_STATUS    = 'h04;
	localparam logic [CFG_AW-1:0] REG_IRQ_MASK  = 'h08;
	localparam logic [CFG_AW-1:0] REG_XFER_CNT  = 'h0C;
	localparam logic [CFG_AW-1:0] REG_MAX_STALL = 'h10;

	// Field positions inside REG_CTRL
	localparam int CTRL_EN_BIT     = 0;
	localparam int CTRL_SLVERR_BIT = 1;
	localparam int CTRL_LIMIT_LSB  = 8;

	// Control values after reset
	localparam logic [STALL_W-1:0] CTRL_RST_LIMIT = 'd4;

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// One sampled APB cycle, prdata is not part of it
	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pready;
		logic              pwrite;
		logic [ADDR_W-1:0] paddr;
		logic [DATA_W-1:0] pwdata;
		logic [STRB_W-1:0] pwstrb;
		logic [2:0]        pprot;
		logic              pslverr;
	} apb_beat_t;

	// Listed from bit 5 down to bit 0, so sel_drop is status bit 0
	typedef struct packed {
		logic slverr_bad;
		logic stall_over;
		logic payload_change;
		logic en_missing;
		logic en_in_setup;
		logic sel_drop;
	} apb_viol_t;

	// One-hot phase flags, all low on a malformed held cycle
	typedef struct packed {
		logic idle;
		logic setup;
		logic wait_st;
		logic done;
	} apb_phase_t;

	// Run-time control fields
	typedef struct packed {
		logic               enable;
		logic               slverr_ok;
		logic [STALL_W-1:0] max_stall;
	} watch_cfg_t;

endpackage

/* hw/apb_phase_tracker.sv */
// APB phase tracker that keeps the last bus cycle and classifies the current one
`timescale 1ns/100ps

module apb_phase_tracker (
	input  logic                     PCLK,
	input  logic                     rst_n,
	input  apb_watch_pkg::apb_beat_t  beat,
	output apb_watch_pkg::apb_phase_t phase,
	output apb_watch_pkg::apb_beat_t  prev_beat,
	output logic                     xfer_done
);

	import apb_watch_pkg::*;

	// Last sampled bus cycle
	apb_beat_t prev_q;

	// Previous cycle ended a transfer
	logic prev_done;

	// Current cycle starts a new transfer
	logic starts;

	// Current cycle is a selected access phase
	logic in_access;

	////////////////////////////////////////////////////////////
	// Previous cycle register
	////////////////////////////////////////////////////////////

	// Cleared at reset so the first cycle sees no prior psel
	always_ff @(posedge PCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			prev_q <= '0;
		end
		else
		begin
			prev_q <= beat;
		end
	end

	////////////////////////////////////////////////////////////
	// Classification
	////////////////////////////////////////////////////////////

	always_comb
	begin
		prev_done = prev_q.psel & prev_q.penable & prev_q.pready;

		// New select, or back to back after a completed access
		starts = beat.psel & (~prev_q.psel | prev_done);

		// Setup wins, so penable high in setup is not an access
		in_access = beat.psel & beat.penable & ~starts;

		phase.idle    = ~beat.psel;
		phase.setup   = starts;
		phase.wait_st = in_access & ~beat.pready;
		phase.done    = in_access & beat.pready;
	end

	// Previous beat goes on to the rule checker
	assign prev_beat = prev_q;

	// Completion pulse for the transfer counter
	assign xfer_done = phase.done;

endmodule

/* hw/apb_rule_checker.sv */
// APB rule checker raising one pulse per broken protocol rule on the offending cycle
`timescale 1ns/100ps

module apb_rule_checker (
	input  apb_watch_pkg::apb_beat_t  beat,
	input  apb_watch_pkg::apb_beat_t  prev_beat,
	input  apb_watch_pkg::apb_phase_t phase,
	input  apb_watch_pkg::watch_cfg_t cfg,
	output apb_watch_pkg::apb_viol_t  viol
);

	import apb_watch_pkg::*;

	// Previous cycle completed an access
	logic prev_done;

	// Previous cycle left a transfer open, that is setup or wait
	logic prev_open;

	// Previous cycle looked like a setup phase
	logic prev_setup;

	// Held control fields moved
	logic ctrl_moved;

	// Held write payload moved
	logic data_moved;

	////////////////////////////////////////////////////////////
	// Previous cycle state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		prev_done  = prev_beat.psel & prev_beat.penable & prev_beat.pready;
		prev_open  = prev_beat.psel & ~prev_done;

		// Open and without penable means the access phase is still due
		prev_setup = prev_beat.psel & ~prev_beat.penable;
	end

	////////////////////////////////////////////////////////////
	// Payload stability
	////////////////////////////////////////////////////////////

	always_comb
	begin
		ctrl_moved = (beat.paddr != prev_beat.paddr)
			| (beat.pwrite != prev_beat.pwrite)
			| (beat.pprot != prev_beat.pprot);

		// Write data and strobes only matter on a write
		data_moved = prev_beat.pwrite
			& ((beat.pwdata != prev_beat.pwdata)
			| (beat.pwstrb != prev_beat.pwstrb));
	end

	////////////////////////////////////////////////////////////
	// Rule pulses
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Deselect before the slave answered
		viol.sel_drop = prev_open & ~beat.psel;

		// Setup must come with penable low
		viol.en_in_setup = phase.setup & beat.penable;

		// Access phase must follow setup while the slave stays selected
		viol.en_missing = prev_setup & beat.psel & ~beat.penable;

		// A deselect is reported as sel_drop only
		viol.payload_change = prev_open & beat.psel & (ctrl_moved | data_moved);

		// The stall timer owns this bit
		viol.stall_over = 1'b0;

		// Error allowed only on a completing access, and only if enabled
		viol.slverr_bad = beat.pslverr & (~phase.done | ~cfg.slverr_ok);
	end

endmodule

/* hw/apb_stall_timer.sv */
// APB stall timer counting wait states and tracking the longest stall
`timescale 1ns/100ps

module apb_stall_timer (
	input  logic                                 PCLK,
	input  logic                                 rst_n,
	input  apb_watch_pkg::apb_phase_t            phase,
	input  apb_watch_pkg::watch_cfg_t            cfg,
	output logic                                 stall_over,
	output logic [apb_watch_pkg::STALL_W-1:0]    max_seen
);

	import apb_watch_pkg::*;

	// Wait states counted before this cycle
	logic [STALL_W-1:0] count_q;

	// Count including this cycle, saturating
	logic [STALL_W-1:0] run;

	// Longest run seen
	logic [STALL_W-1:0] max_q;

	always_comb
	begin
		if (!phase.wait_st)
			run = '0;
		else if (count_q == '1)
			run = count_q;
		else
			run = count_q + 1'b1;

		// A limit of zero turns the check off
		stall_over = phase.wait_st & (cfg.max_stall != '0) & (run > cfg.max_stall);
	end

	always_ff @(posedge PCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count_q <= '0;
			max_q   <= '0;
		end
		else
		begin
			count_q <= run;
			// Record only while monitoring is on
			if (cfg.enable && phase.wait_st && (run > max_q))
				max_q <= run;
		end
	end

	assign max_seen = max_q;

endmodule

/* hw/apb_watch_regs.sv */
// APB watch register block with control, sticky status, mask, counters and interrupt
`timescale 1ns/100ps

module apb_watch_regs (
	input  logic                               PCLK,
	input  logic                               rst_n,
	input  logic                               cfg_wr,
	input  logic                               cfg_rd,
	input  logic [apb_watch_pkg::CFG_AW-1:0]   cfg_addr,
	input  logic [apb_watch_pkg::CFG_DW-1:0]   cfg_wdata,
	output logic [apb_watch_pkg::CFG_DW-1:0]   cfg_rdata,
	output apb_watch_pkg::watch_cfg_t          cfg,
	input  apb_watch_pkg::apb_viol_t           viol,
	input  logic                               xfer_done,
	input  logic [apb_watch_pkg::STALL_W-1:0]  max_seen,
	output logic                               irq
);

	import apb_watch_pkg::*;

	// Register state
	watch_cfg_t         cfg_q;
	logic [VIOL_N-1:0]  status_q;
	logic [VIOL_N-1:0]  mask_q;
	logic [CFG_DW-1:0]  xfer_cnt_q;
	logic               irq_q;
	logic [CFG_DW-1:0]  rdata_q;

	// Write decode
	logic wr_ctrl;
	logic wr_status;
	logic wr_mask;

	// Status update terms
	logic [VIOL_N-1:0] viol_set;
	logic [VIOL_N-1:0] w1c;

	// Read mux output
	logic [CFG_DW-1:0] rd_word;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	always_comb
	begin
		wr_ctrl   = cfg_wr & (cfg_addr == REG_CTRL);
		wr_status = cfg_wr & (cfg_addr == REG_STATUS);
		wr_mask   = cfg_wr & (cfg_addr == REG_IRQ_MASK);

		// New violations count only while monitoring is on
		viol_set = cfg_q.enable ? VIOL_N'(viol) : '0;
		w1c      = wr_status ? cfg_wdata[VIOL_N-1:0] : '0;
	end

	////////////////////////////////////////////////////////////
	// Control, status, mask and counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge PCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg_q.enable    <= 1'b1;
			cfg_q.slverr_ok <= 1'b1;
			cfg_q.max_stall <= CTRL_RST_LIMIT;
			status_q        <= '0;
			mask_q          <= '0;
			xfer_cnt_q      <= '0;
			irq_q           <= 1'b0;
		end
		else
		begin
			if (wr_ctrl)
			begin
				cfg_q.enable    <= cfg_wdata[CTRL_EN_BIT];
				cfg_q.slverr_ok <= cfg_wdata[CTRL_SLVERR_BIT];
				cfg_q.max_stall <= cfg_wdata[CTRL_LIMIT_LSB +: STALL_W];
			end
			if (wr_mask)
				mask_q <= cfg_wdata[VIOL_N-1:0];

			// Clear first, a violation in the same cycle still sets
			status_q <= (status_q & ~w1c) | viol_set;

			// Wraps at the full counter width
			if (cfg_q.enable && xfer_done)
				xfer_cnt_q <= xfer_cnt_q + 1'b1;

			// One cycle behind the masked status
			irq_q <= |(status_q & mask_q);
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_word = '0;
		case (cfg_addr)
			REG_CTRL:
			begin
				rd_word[CTRL_EN_BIT]                 = cfg_q.enable;
				rd_word[CTRL_SLVERR_BIT]             = cfg_q.slverr_ok;
				rd_word[CTRL_LIMIT_LSB +: STALL_W]   = cfg_q.max_stall;
			end
			REG_STATUS:    rd_word[VIOL_N-1:0]  = status_q;
			REG_IRQ_MASK:  rd_word[VIOL_N-1:0]  = mask_q;
			REG_XFER_CNT:  rd_word              = xfer_cnt_q;
			REG_MAX_STALL: rd_word[STALL_W-1:0] = max_seen;
			// Unmapped offsets read as zero
			default:       rd_word = '0;
		endcase
	end

	// Read data holds until the next read strobe
	always_ff @(posedge PCLK or negedge rst_n)
	begin
		if (!rst_n)
			rdata_q <= '0;
		else if (cfg_rd)
			rdata_q <= rd_word;
	end

	assign cfg       = cfg_q;
	assign cfg_rdata = rdata_q;
	assign irq       = irq_q;

endmodule

/* hw/apb_watch_top.sv */
// APB watch top level joining phase tracker, rule checker, stall timer and registers
`timescale 1ns/100ps

module apb_watch_top (
	input  logic                               PCLK,
	input  logic                               rst_n,
	// Observed APB segment, inputs only
	input  logic                               psel,
	input  logic                               penable,
	input  logic                               pready,
	input  logic                               pwrite,
	input  logic [apb_watch_pkg::ADDR_W-1:0]   paddr,
	input  logic [apb_watch_pkg::DATA_W-1:0]   pwdata,
	input  logic [apb_watch_pkg::DATA_W-1:0]   prdata,
	input  logic [apb_watch_pkg::STRB_W-1:0]   pwstrb,
	input  logic [2:0]                         pprot,
	input  logic                               pslverr,
	// Configuration port
	input  logic                               cfg_wr,
	input  logic                               cfg_rd,
	input  logic [apb_watch_pkg::CFG_AW-1:0]   cfg_addr,
	input  logic [apb_watch_pkg::CFG_DW-1:0]   cfg_wdata,
	output logic [apb_watch_pkg::CFG_DW-1:0]   cfg_rdata,
	output logic                               irq
);

	import apb_watch_pkg::*;

	apb_beat_t          beat;
	apb_beat_t          prev_beat;
	apb_phase_t         phase;
	watch_cfg_t         cfg;
	apb_viol_t          viol_chk;
	apb_viol_t          viol;
	logic               xfer_done;
	logic               stall_over;
	logic [STALL_W-1:0] max_seen;

	// Pack the bus, prdata is taken in for a full port but never checked
	always_comb
	begin
		beat.psel    = psel;
		beat.penable = penable;
		beat.pready  = pready;
		beat.pwrite  = pwrite;
		beat.paddr   = paddr;
		beat.pwdata  = pwdata;
		beat.pwstrb  = pwstrb;
		beat.pprot   = pprot;
		beat.pslverr = pslverr;
	end

	// Checker bits plus the stall flag from the timer
	always_comb
	begin
		viol            = viol_chk;
		viol.stall_over = stall_over;
	end

	apb_phase_tracker u_tracker (
		.PCLK      (PCLK),
		.rst_n     (rst_n),
		.beat      (beat),
		.phase     (phase),
		.prev_beat (prev_beat),
		.xfer_done (xfer_done)
	);

	apb_rule_checker u_checker (
		.beat      (beat),
		.prev_beat (prev_beat),
		.phase     (phase),
		.cfg       (cfg),
		.viol      (viol_chk)
	);

	apb_stall_timer u_timer (
		.PCLK       (PCLK),
		.rst_n      (rst_n),
		.phase      (phase),
		.cfg        (cfg),
		.stall_over (stall_over),
		.max_seen   (max_seen)
	);

	apb_watch_regs u_regs (
		.PCLK      (PCLK),
		.rst_n     (rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_rd    (cfg_rd),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.cfg       (cfg),
		.viol      (viol),
		.xfer_done (xfer_done),
		.max_seen  (max_seen),
		.irq       (irq)
	);

endmodule

/* bench/tb_clock_gen.sv */
// Clock and reset source for the APB watch testbench
`timescale 1ns/100ps

module tb_clock_gen (
	output logic PCLK,
	output logic rst_n
);

	// 8 ns period
	localparam real HALF_PERIOD = 4.0;

	// Rising edges spent in reset
	localparam int RST_CYCLES = 3;

	initial
	begin
		PCLK = 1'b0;
		forever
			#(HALF_PERIOD) PCLK = ~PCLK;
	end

	// Released on an edge so the first bus line starts clean
	initial
	begin
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge PCLK);
		rst_n <= 1'b1;
	end

endmodule

/* bench/tb_checker.sv */
// Response checker comparing irq and configuration read data with the expected values
`timescale 1ns/100ps

module tb_checker (
	input  logic                              PCLK,
	input  logic                              rst_n,
	input  logic                              irq,
	input  logic [apb_watch_pkg::CFG_DW-1:0]  cfg_rdata,
	input  logic                              exp_irq_vld,
	input  logic                              exp_irq,
	input  logic                              exp_rd_vld,
	input  logic [apb_watch_pkg::CFG_DW-1:0]  exp_rd,
	output int                                irq_errs,
	output int                                rd_errs
);

	import apb_watch_pkg::*;

	// irq expectation, two stages for status then the irq register
	logic [1:0] irq_vld_q;
	logic [1:0] irq_exp_q;

	// Read expectation, read data is registered once
	logic              rd_vld_q;
	logic [CFG_DW-1:0] rd_exp_q;

	////////////////////////////////////////////////////////////
	// Expectation pipeline
	////////////////////////////////////////////////////////////

	always @(posedge PCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			irq_vld_q <= '0;
			irq_exp_q <= '0;
			rd_vld_q  <= 1'b0;
			rd_exp_q  <= '0;
		end
		else
		begin
			irq_vld_q <= {irq_vld_q[0], exp_irq_vld};
			irq_exp_q <= {irq_exp_q[0], exp_irq};
			rd_vld_q  <= exp_rd_vld;
			rd_exp_q  <= exp_rd;
		end
	end

	initial
	begin
		irq_errs = 0;
		rd_errs  = 0;
	end

	////////////////////////////////////////////////////////////
	// Compare
	////////////////////////////////////////////////////////////

	// Mid cycle, DUT outputs have settled
	always @(negedge PCLK)
	begin
		if (irq_vld_q[1] && (irq !== irq_exp_q[1]))
		begin
			$display("** Error: irq = 0x%0h, expected 0x%0h at %0t",
				irq, irq_exp_q[1], $time);
			irq_errs++;
		end
		if (rd_vld_q && (cfg_rdata !== rd_exp_q))
		begin
			$display("** Error: cfg_rdata = 0x%08h, expected 0x%08h at %0t",
				cfg_rdata, rd_exp_q, $time);
			rd_errs++;
		end
	end

endmodule

/* bench/tb_apb_watch.sv */
// Testbench top running a table of APB cycles and register accesses through the APB watch
`timescale 1ns/100ps

module tb_apb_watch;

	import apb_watch_pkg::*;

	// Seven hex words per table line
	localparam int COLS      = 7;
	localparam int MAX_LINES = 96;
	localparam int RST_LIMIT = 20;

	// Table operation codes
	localparam logic [31:0] OP_BUS  = 32'hB;
	localparam logic [31:0] OP_WR   = 32'hC;
	localparam logic [31:0] OP_RD   = 32'hD;
	localparam logic [31:0] OP_END  = 32'hE;

	logic PCLK;
	logic rst_n;

	// Observed bus
	logic              psel;
	logic              penable;
	logic              pready;
	logic              pwrite;
	logic [ADDR_W-1:0] paddr;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic [STRB_W-1:0] pwstrb;
	logic [2:0]        pprot;
	logic              pslverr;

	// Configuration port
	logic              cfg_wr;
	logic              cfg_rd;
	logic [CFG_AW-1:0] cfg_addr;
	logic [CFG_DW-1:0] cfg_wdata;
	logic [CFG_DW-1:0] cfg_rdata;
	logic              irq;

	// Handed to the checker
	logic              exp_irq_vld;
	logic              exp_irq;
	logic              exp_rd_vld;
	logic [CFG_DW-1:0] exp_rd;
	int                irq_errs;
	int                rd_errs;

	// Test table and run state
	logic [31:0] tests_mem [0:COLS*MAX_LINES-1];
	integer      seed;
	int          other_errs;
	int          line_idx;
	int          cycles;
	logic        at_end;

	tb_clock_gen u_clk (
		.PCLK  (PCLK),
		.rst_n (rst_n)
	);

	apb_watch_top DUT (
		.PCLK      (PCLK),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pready    (pready),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pwstrb    (pwstrb),
		.pprot     (pprot),
		.pslverr   (pslverr),
		.cfg_wr    (cfg_wr),
		.cfg_rd    (cfg_rd),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata),
		.irq       (irq)
	);

	tb_checker u_chk (
		.PCLK        (PCLK),
		.rst_n       (rst_n),
		.irq         (irq),
		.cfg_rdata   (cfg_rdata),
		.exp_irq_vld (exp_irq_vld),
		.exp_irq     (exp_irq),
		.exp_rd_vld  (exp_rd_vld),
		.exp_rd      (exp_rd),
		.irq_errs    (irq_errs),
		.rd_errs     (rd_errs)
	);

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// Deselected bus, payload filled with noise
	task drive_idle_bus;
	begin
		psel    <= 1'b0;
		penable <= 1'b0;
		pready  <= 1'b0;
		pwrite  <= 1'b0;
		pslverr <= 1'b0;
		paddr   <= '0;
		pwstrb  <= '0;
		pprot   <= '0;
		pwdata  <= $random(seed);
	end
	endtask

	// One table line for the cycle that starts at this edge
	task apply_line(input int idx);
		logic [31:0] op;
		logic [31:0] ctl;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] irqx;
	begin
		op   = tests_mem[idx*COLS];
		ctl  = tests_mem[idx*COLS+1];
		addr = tests_mem[idx*COLS+2];
		data = tests_mem[idx*COLS+3];
		irqx = tests_mem[idx*COLS+6];
		cfg_wr      <= 1'b0;
		cfg_rd      <= 1'b0;
		exp_rd_vld  <= 1'b0;
		exp_irq_vld <= 1'b1;
		exp_irq     <= irqx[0];
		prdata      <= $random(seed);
		drive_idle_bus();
		case (op)
			OP_BUS:
			begin
				// One nibble per flag in the ctl column
				psel    <= ctl[16];
				penable <= ctl[12];
				pready  <= ctl[8];
				pwrite  <= ctl[4];
				pslverr <= ctl[0];
				paddr   <= addr;
				pwstrb  <= tests_mem[idx*COLS+4][STRB_W-1:0];
				pprot   <= tests_mem[idx*COLS+5][2:0];
				if (ctl[16])
					pwdata <= data;
			end
			OP_WR:
			begin
				cfg_wr    <= 1'b1;
				cfg_addr  <= addr[CFG_AW-1:0];
				cfg_wdata <= data;
			end
			OP_RD:
			begin
				cfg_rd     <= 1'b1;
				cfg_addr   <= addr[CFG_AW-1:0];
				exp_rd_vld <= 1'b1;
				exp_rd     <= data;
			end
			OP_END:
			begin
				at_end = 1'b1;
				exp_irq_vld <= 1'b0;
			end
			default:
			begin
				$display("Unknown operation code %0h on test line %0d", op, idx);
				exp_irq_vld <= 1'b0;
				other_errs++;
			end
		endcase
	end
	endtask

	initial
	begin
		// All DUT inputs known from time zero
		psel        = 1'b0;
		penable     = 1'b0;
		pready      = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		prdata      = '0;
		pwstrb      = '0;
		pprot       = '0;
		pslverr     = 1'b0;
		cfg_wr      = 1'b0;
		cfg_rd      = 1'b0;
		cfg_addr    = '0;
		cfg_wdata   = '0;
		exp_irq_vld = 1'b0;
		exp_irq     = 1'b0;
		exp_rd_vld  = 1'b0;
		exp_rd      = '0;
		seed        = 96284;
		other_errs  = 0;
		at_end      = 1'b0;
		$readmemh("bench/apb_watch_tests.txt", tests_mem);

		cycles = 0;
		while ((rst_n !== 1'b1) && (cycles < RST_LIMIT))
		begin
			@(posedge PCLK);
			cycles++;
		end

		if (rst_n !== 1'b1)
		begin
			$display("Reset was not released within %0d cycles", RST_LIMIT);
			other_errs++;
		end
		else
		begin
			line_idx = 0;
			while (!at_end && (line_idx < MAX_LINES))
			begin
				@(posedge PCLK);
				apply_line(line_idx);
				line_idx++;
			end
			if (!at_end)
			begin
				$display("No end marker within the first %0d test lines", MAX_LINES);
				other_errs++;
			end
		end

		// Last irq and read checks land two cycles after the end line
		repeat (3) @(posedge PCLK);
		$display("Errors: irq %0d, read data %0d, other %0d", irq_errs, rd_errs, other_errs);
		if ((irq_errs + rd_errs + other_errs) == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* bench/apb_watch_tests.txt */
// Columns (hex): op ctl addr data strb prot irq; op B bus, C cfg write, D cfg read, E end
// ctl nibbles psel penable pready pwrite pslverr; D data is the expected read word
// irq is the level expected once this line has passed through status and the irq register
// Clean traffic, no wait then three waits
B 10010 00000100 00000011 F 0 0
B 11110 00000100 00000011 F 0 0
B 10000 00000104 00000000 0 2 0
B 11000 00000104 00000000 0 2 0
B 11000 00000104 00000000 0 2 0
B 11000 00000104 00000000 0 2 0
B 11100 00000104 00000000 0 2 0
B 00000 00000000 00000000 0 0 0
D 00000 04 00000000 0 0 0
D 00000 0C 00000002 0 0 0
D 00000 10 00000003 0 0 0
// PENABLE in setup, then a setup without access phase
C 00000 08 0000003F 0 0 0
B 11010 00000200 00000005 F 0 1
B 11110 00000200 00000005 F 0 1
B 10010 00000300 00000007 F 0 1
B 10010 00000300 00000007 F 0 1
B 11110 00000300 00000007 F 0 1
D 00000 04 00000006 0 0 1
C 00000 04 00000006 0 0 0
// Address moves in a wait, write data moves, then deselect mid transfer
B 10010 00000400 000000AA F 0 0
B 11010 00000400 000000AA F 0 0
B 11010 00000404 000000AA F 0 1
B 11110 00000404 000000AA F 0 1
B 10010 00000500 00000010 F 0 1
B 11010 00000500 00000011 F 0 1
B 00000 00000000 00000000 0 0 1
D 00000 04 00000009 0 0 1
C 00000 04 0000003F 0 0 0
// Limit 2, three waits flag and two waits pass
C 00000 00 00000203 0 0 0
B 10000 00000600 00000000 0 0 0
B 11000 00000600 00000000 0 0 0
B 11000 00000600 00000000 0 0 0
B 11000 00000600 00000000 0 0 1
B 11100 00000600 00000000 0 0 1
B 10000 00000604 00000000 0 0 1
B 11000 00000604 00000000 0 0 1
B 11000 00000604 00000000 0 0 1
B 11100 00000604 00000000 0 0 1
D 00000 04 00000010 0 0 1
C 00000 04 00000010 0 0 0
// Limit 0 never flags
C 00000 00 00000003 0 0 0
B 10000 00000608 00000000 0 0 0
B 11000 00000608 00000000 0 0 0
B 11000 00000608 00000000 0 0 0
B 11000 00000608 00000000 0 0 0
B 11100 00000608 00000000 0 0 0
D 00000 04 00000000 0 0 0
// Slave error on done is allowed, in a wait it is not, then errors disabled
B 10010 00000700 00000001 F 0 0
B 11111 00000700 00000001 F 0 0
B 10010 00000704 00000002 F 0 0
B 11011 00000704 00000002 F 0 1
B 11110 00000704 00000002 F 0 1
C 00000 04 00000020 0 0 0
C 00000 00 00000001 0 0 0
B 10010 00000708 00000003 F 0 0
B 11111 00000708 00000003 F 0 1
D 00000 04 00000020 0 0 1
// Clear drops irq, monitoring off ignores violations and transfers
C 00000 04 00000020 0 0 0
C 00000 00 00000002 0 0 0
B 11010 00000800 00000004 F 0 0
B 11110 00000800 00000004 F 0 0
B 10010 00000804 00000005 F 0 0
B 00000 00000000 00000000 0 0 0
D 00000 04 00000000 0 0 0
D 00000 0C 0000000B 0 0 0
E 00000 00 00000000 0 0 0

/* apb_watch.f */
hw/apb_watch_pkg.sv
hw/apb_phase_tracker.sv
hw/apb_rule_checker.sv
hw/apb_stall_timer.sv
hw/apb_watch_regs.sv
hw/apb_watch_top.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/tb_apb_watch.sv
